//--- hdl/ctrl_status.sv
// Builds the controls and status words read by the CPU and drives the
// front end reset pins from the system control word.
// Buttons are asynchronous and active low; they pass two flops before
// the word register, so controls_o sees them 3 cycles later.
// IR fields, memory status and card detect are assumed synchronous
// and reach their words after 1 cycle.

`include "ossc_io_cfg.svh"

module ctrl_status
    import ossc_io_pkg::*;
(
    input  logic                       CLK27_i,
    input  logic                       po_reset_n,
    input  sys_ctrl_t                  sys_ctrl_i,
    input  logic [`OSSC_BTN_W-1:0]     btn_i,
    input  logic [`OSSC_IR_CODE_W-1:0] ir_code_i,
    input  logic [`OSSC_IR_CNT_W-1:0]  ir_code_cnt_i,
    input  logic                       sd_detect_n_i,
    input  mem_status_t                mem_status_i,
    output logic [`OSSC_WORD_W-1:0]    controls_o,
    output logic [`OSSC_WORD_W-1:0]    status_o,
    output logic                       isl_reset_n_o,
    output logic                       hdmirx_reset_n_o,
    output logic                       audmux_o
);

    localparam int CTRL_PAD_W = `OSSC_WORD_W - `OSSC_BTN_W - `OSSC_IR_CNT_W
                                - `OSSC_IR_CODE_W;
    localparam int STAT_PAD_W = `OSSC_WORD_W - 1 - $bits(mem_status_t);

    logic [`OSSC_BTN_W-1:0]  btn_sync1;
    logic [`OSSC_BTN_W-1:0]  btn_sync2;
    logic [`OSSC_WORD_W-1:0] controls_next;
    logic [`OSSC_WORD_W-1:0] status_next;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1 <= `OSSC_BTN_RESET;
            btn_sync2 <= `OSSC_BTN_RESET;
        end else begin
            btn_sync1 <= btn_i;
            btn_sync2 <= btn_sync1;
        end
    end

    // Controls: pad, buttons, IR count, IR code
    assign controls_next = {{CTRL_PAD_W{1'b0}}, btn_sync2, ir_code_cnt_i, ir_code_i};

    // Status: pad, card present, memory status with init_done at bit 0
    assign status_next = {{STAT_PAD_W{1'b0}}, ~sd_detect_n_i, mem_status_i};

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            controls_o <= '0;
            status_o   <= '0;
        end else begin
            controls_o <= controls_next;
            status_o   <= status_next;
        end
    end

    assign isl_reset_n_o    = sys_ctrl_i.isl_reset_n;
    assign hdmirx_reset_n_o = sys_ctrl_i.hdmirx_reset_n;

    // Audio mux select pin is inverted on the board
    assign audmux_o = ~sys_ctrl_i.audmux_sel;

endmodule

//--- hdl/led_status.sv
// Front panel LED driver with the resync indicator.
// The resync strobe may come from another clock domain and passes a
// two-flop synchronizer before edge detection. Each rising edge lights
// red for 2^LED_CTR_W-1 cycles while powered on. In standby the same
// counter runs free as a heartbeat until the PLL locks.

`include "ossc_io_cfg.svh"

module led_status
    import ossc_io_pkg::*;
#(
    parameter int LED_CTR_W = `OSSC_LED_CTR_W
) (
    input  logic                       CLK27_i,
    input  logic                       po_reset_n,
    input  logic                       poweron_i,
    input  logic                       framelock_i,
    input  logic                       pll_locked_i,
    input  logic [`OSSC_IR_CODE_W-1:0] ir_code_i,
    input  logic                       resync_strobe_i,
    output led_t                       led_o
);

    logic                 strobe_sync1;
    logic                 strobe_sync2;
    logic                 strobe_prev;
    logic                 strobe_rise;
    logic [LED_CTR_W-1:0] led_ctr;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync1 <= 1'b0;
            strobe_sync2 <= 1'b0;
            strobe_prev  <= 1'b0;
        end else begin
            strobe_sync1 <= resync_strobe_i;
            strobe_sync2 <= strobe_sync1;
            strobe_prev  <= strobe_sync2;
        end
    end

    assign strobe_rise = strobe_sync2 & ~strobe_prev;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            led_ctr <= '0;
        end else if (poweron_i) begin
            if (strobe_rise) begin
                led_ctr <= '1;
            end else if (led_ctr != '0) begin
                led_ctr <= led_ctr - 1'b1;
            end
        end else if (pll_locked_i) begin
            led_ctr <= '0;
        end else begin
            // Heartbeat while waiting for PLL lock
            led_ctr <= led_ctr - 1'b1;
        end
    end

    always_comb begin
        if (poweron_i) begin
            led_o.blue  = framelock_i;
            led_o.green = (ir_code_i == '0);
            led_o.red   = (led_ctr != '0);
        end else begin
            led_o.blue  = 1'b0;
            led_o.green = 1'b0;
            led_o.red   = ~led_ctr[LED_CTR_W-1];
        end
    end

endmodule

//--- hdl/osd_overlay.sv
// Mixes the OSD over the scaler output and registers the result to the
// HDMI transmitter pins. Two register stages, so 2 cycles latency.
// The OSD replaces the pixel colour outright; there is no blending.
// Syncs and DE pass through untouched to keep the timing intact.

`include "ossc_io_cfg.svh"

module osd_overlay
    import ossc_io_pkg::*;
(
    input  logic   CLK27_i,
    input  logic   po_reset_n,
    input  pixel_t sc_pixel_i,
    input  osd_t   osd_i,
    output pixel_t tx_pixel_o
);

    logic [3*`OSSC_COLOR_W-1:0] osd_rgb;
    pixel_t                     mix_pixel;
    pixel_t                     mix_q;

    always_comb begin
        case (osd_i.color)
            2'd0:    osd_rgb = `OSSC_OSD_COLOR_0;
            2'd1:    osd_rgb = `OSSC_OSD_COLOR_1;
            2'd2:    osd_rgb = `OSSC_OSD_COLOR_2;
            default: osd_rgb = `OSSC_OSD_COLOR_3;
        endcase
    end

    always_comb begin
        mix_pixel = sc_pixel_i;
        if (osd_i.enable) begin
            {mix_pixel.r, mix_pixel.g, mix_pixel.b} = osd_rgb;
        end
    end

    // Stage one holds the mixed pixel
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            mix_q <= '0;
        end else begin
            mix_q <= mix_pixel;
        end
    end

    // Stage two sits next to the transmitter pins
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            tx_pixel_o <= '0;
        end else begin
            tx_pixel_o <= mix_q;
        end
    end

endmodule

//--- hdl/ossc_io.sv
// Board glue top level for the scan converter, single clock CLK27_i.
// The CPU, memory, front ends and scaler core live outside; their
// signals arrive here as plain inputs and leave as plain outputs.
// po_reset_n is an external asynchronous active low reset.
// All inputs are levels or strobes sampled each cycle, no handshakes.

`include "ossc_io_cfg.svh"

module ossc_io
    import ossc_io_pkg::*;
#(
    parameter int LED_CTR_W = `OSSC_LED_CTR_W
) (
    input  logic                       CLK27_i,
    input  logic                       po_reset_n,

    input  sys_ctrl_t                  sys_ctrl_i,

    input  capt_pixel_t                isl_pixel_i,
    input  capt_pixel_t                hdmirx_pixel_i,
    input  i2s_t                       hdmirx_i2s_i,
    input  i2s_t                       pcm_i2s_i,
    input  logic                       hdmirx_ap_i,
    input  logic                       spdif_ext_i,

    input  logic [`OSSC_BTN_W-1:0]     btn_i,
    input  logic [`OSSC_IR_CODE_W-1:0] ir_code_i,
    input  logic [`OSSC_IR_CNT_W-1:0]  ir_code_cnt_i,
    input  logic                       sd_detect_n_i,
    input  mem_status_t                mem_status_i,

    input  logic                       pll_locked_i,
    input  logic                       resync_strobe_i,

    input  pixel_t                     sc_pixel_i,
    input  osd_t                       osd_i,

    output capt_pixel_t                capt_pixel_o,
    output logic [`OSSC_WORD_W-1:0]    controls_o,
    output logic [`OSSC_WORD_W-1:0]    status_o,
    output led_t                       led_o,
    output logic                       ISL_RESET_N_o,
    output logic                       HDMIRX_RESET_N_o,
    output logic                       AUDMUX_o,
    output i2s_t                       HDMITX_I2S_o,
    output logic                       HDMITX_SPDIF_o,
    output pixel_t                     HDMITX_PIXEL_o
);

    source_select u_source_select (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (sys_ctrl_i.capture_sel),
        .hdmirx_spdif_i (sys_ctrl_i.hdmirx_spdif),
        .isl_pixel_i    (isl_pixel_i),
        .hdmirx_pixel_i (hdmirx_pixel_i),
        .hdmirx_i2s_i   (hdmirx_i2s_i),
        .pcm_i2s_i      (pcm_i2s_i),
        .hdmirx_ap_i    (hdmirx_ap_i),
        .spdif_ext_i    (spdif_ext_i),
        .capt_pixel_o   (capt_pixel_o),
        .tx_i2s_o       (HDMITX_I2S_o),
        .tx_spdif_o     (HDMITX_SPDIF_o)
    );

    ctrl_status u_ctrl_status (
        .CLK27_i          (CLK27_i),
        .po_reset_n       (po_reset_n),
        .sys_ctrl_i       (sys_ctrl_i),
        .btn_i            (btn_i),
        .ir_code_i        (ir_code_i),
        .ir_code_cnt_i    (ir_code_cnt_i),
        .sd_detect_n_i    (sd_detect_n_i),
        .mem_status_i     (mem_status_i),
        .controls_o       (controls_o),
        .status_o         (status_o),
        .isl_reset_n_o    (ISL_RESET_N_o),
        .hdmirx_reset_n_o (HDMIRX_RESET_N_o),
        .audmux_o         (AUDMUX_o)
    );

    led_status #(
        .LED_CTR_W (LED_CTR_W)
    ) u_led_status (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .poweron_i       (sys_ctrl_i.poweron),
        .framelock_i     (sys_ctrl_i.framelock),
        .pll_locked_i    (pll_locked_i),
        .ir_code_i       (ir_code_i),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_o)
    );

    osd_overlay u_osd_overlay (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .sc_pixel_i (sc_pixel_i),
        .osd_i      (osd_i),
        .tx_pixel_o (HDMITX_PIXEL_o)
    );

endmodule

//--- hdl/ossc_io_cfg.svh
// Shared widths and constants for the scan converter board glue.
// Every RTL file and the testbench include this header. The package
// builds its packed types from the widths below, so a change here
// reshapes every port that carries a pixel or a CPU word.
// OSD colours are 24-bit RGB and assume OSSC_COLOR_W is 8.

`ifndef OSSC_IO_CFG_SVH
`define OSSC_IO_CFG_SVH

// Video channel width
`define OSSC_COLOR_W 8

// Front panel and IR receiver
`define OSSC_BTN_W 6
`define OSSC_IR_CODE_W 16
`define OSSC_IR_CNT_W 8

// CPU PIO word width
`define OSSC_WORD_W 32

// Resync indicator counter, about 0.6 s at 27 MHz
`define OSSC_LED_CTR_W 24

// OSD palette, indexed by osd_t.color
`define OSSC_OSD_COLOR_0 24'h000000
`define OSSC_OSD_COLOR_1 24'h0000ff
`define OSSC_OSD_COLOR_2 24'hffff00
`define OSSC_OSD_COLOR_3 24'hffffff

// Buttons are active low, so the synchronizer idles high
`define OSSC_BTN_RESET {`OSSC_BTN_W{1'b1}}

`endif

//--- hdl/ossc_io_pkg.sv
// Packed types shared by the board glue modules and the testbench.
// Field order inside each struct fixes the bit layout seen by the CPU,
// so sys_ctrl_t must stay in step with the PIO register map.

`include "ossc_io_cfg.svh"

package ossc_io_pkg;

    // RGB plus syncs, 27 bits
    typedef struct packed {
        logic [`OSSC_COLOR_W-1:0] r;
        logic [`OSSC_COLOR_W-1:0] g;
        logic [`OSSC_COLOR_W-1:0] b;
        logic                     hsync;
        logic                     vsync;
        logic                     de;
    } pixel_t;

    // Front end output with field and frame info
    typedef struct packed {
        pixel_t pix;
        logic   fid;
        logic   interlace;
        logic   frame_change;
    } capt_pixel_t;

    // System control word from the CPU, poweron at bit 0
    typedef struct packed {
        logic hdmirx_spdif;
        logic framelock;
        logic csc;
        logic testpattern;
        logic audmux_sel;
        logic isl_vsync_type;
        logic isl_vsync_pol;
        logic isl_hsync_pol;
        logic capture_sel;
        logic mem_mpfe_reset_n;
        logic mem_powerdn_req;
        logic mem_swreset_n;
        logic mem_hwreset_n;
        logic hdmirx_reset_n;
        logic isl_reset_n;
        logic poweron;
    } sys_ctrl_t;

    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } i2s_t;

    typedef struct packed {
        logic       enable;
        logic [1:0] color;
    } osd_t;

    // LPDDR2 controller status, init_done at bit 0
    typedef struct packed {
        logic pll_locked;
        logic powerdn_ack;
        logic cal_fail;
        logic cal_success;
        logic init_done;
    } mem_status_t;

    // Front panel LED, red at bit 0
    typedef struct packed {
        logic blue;
        logic green;
        logic red;
    } led_t;

endpackage

//--- hdl/source_select.sv
// Selects the capture source between the analog digitizer and the HDMI
// receiver, and routes audio to the HDMI transmitter.
// Both video sources are assumed to be already in the CLK27_i domain.
// Latency: analog 2 cycles, HDMI 3 cycles, capture_sel_i 1 cycle.
// Audio routing is purely combinational; no clock recovery is done.

`include "ossc_io_cfg.svh"

module source_select
    import ossc_io_pkg::*;
(
    input  logic        CLK27_i,
    input  logic        po_reset_n,
    input  logic        capture_sel_i,
    input  logic        hdmirx_spdif_i,
    input  capt_pixel_t isl_pixel_i,
    input  capt_pixel_t hdmirx_pixel_i,
    input  i2s_t        hdmirx_i2s_i,
    input  i2s_t        pcm_i2s_i,
    input  logic        hdmirx_ap_i,
    input  logic        spdif_ext_i,
    output capt_pixel_t capt_pixel_o,
    output i2s_t        tx_i2s_o,
    output logic        tx_spdif_o
);

    capt_pixel_t isl_q;
    capt_pixel_t hdmirx_q1;
    capt_pixel_t hdmirx_q2;
    i2s_t        hdmirx_i2s_ap;

    // Analog port gets one input stage
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            isl_q <= '0;
        end else begin
            isl_q <= isl_pixel_i;
        end
    end

    // HDMI receiver port gets two, as on the board
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmirx_q1 <= '0;
            hdmirx_q2 <= '0;
        end else begin
            hdmirx_q1 <= hdmirx_pixel_i;
            hdmirx_q2 <= hdmirx_q1;
        end
    end

    // Capture mux register
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            capt_pixel_o <= '0;
        end else if (capture_sel_i) begin
            capt_pixel_o <= hdmirx_q2;
        end else begin
            capt_pixel_o <= isl_q;
        end
    end

    // Receiver I2S carries its data on the shared audio pin
    always_comb begin
        hdmirx_i2s_ap      = hdmirx_i2s_i;
        hdmirx_i2s_ap.data = hdmirx_ap_i;
    end

    assign tx_i2s_o   = capture_sel_i ? hdmirx_i2s_ap : pcm_i2s_i;
    assign tx_spdif_o = hdmirx_spdif_i ? hdmirx_ap_i : spdif_ext_i;

endmodule

//--- ossc_io.f
+incdir+hdl
hdl/ossc_io_pkg.sv
hdl/source_select.sv
hdl/ctrl_status.sv
hdl/led_status.sv
hdl/osd_overlay.sv
hdl/ossc_io.sv
verification/tb_ossc_io.sv

//--- verification/tb_ossc_io.sv
// Directed testbench for the scan converter board glue.
// Inputs change on the rising edge of CLK27_i and outputs are sampled on
// the falling edge. The resync counter is cut to 6 bits so the indicator
// test runs in under a hundred cycles. Random data comes from a 16-bit
// Galois LFSR that steps once per bit taken.

`include "ossc_io_cfg.svh"

module tb_ossc_io
    import ossc_io_pkg::*;
();

    localparam int LED_W       = 6;
    localparam int CTR_CYCLES  = 1 << LED_W;
    localparam int STREAM_LEN  = 8;
    localparam int WORD_ROUNDS = 6;
    // Budget per test: reset, capture, overlay, resync, CPU words
    localparam int TEST_CYCLES = 10 + 2 * (STREAM_LEN + 8) + (STREAM_LEN + 4)
                                 + (2 * CTR_CYCLES + 32) + 5 * WORD_ROUNDS;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam logic [3:0][23:0] OSD_PALETTE = {`OSSC_OSD_COLOR_3, `OSSC_OSD_COLOR_2,
                                                `OSSC_OSD_COLOR_1, `OSSC_OSD_COLOR_0};

    logic                       CLK27_i         = 1'b0;
    logic                       po_reset_n      = 1'b0;
    sys_ctrl_t                  sys_ctrl_i      = '0;
    capt_pixel_t                isl_pixel_i     = '0;
    capt_pixel_t                hdmirx_pixel_i  = '0;
    i2s_t                       hdmirx_i2s_i    = '0;
    i2s_t                       pcm_i2s_i       = '0;
    logic                       hdmirx_ap_i     = 1'b0;
    logic                       spdif_ext_i     = 1'b0;
    logic [`OSSC_BTN_W-1:0]     btn_i           = '1;
    logic [`OSSC_IR_CODE_W-1:0] ir_code_i       = '0;
    logic [`OSSC_IR_CNT_W-1:0]  ir_code_cnt_i   = '0;
    logic                       sd_detect_n_i   = 1'b1;
    mem_status_t                mem_status_i    = '0;
    logic                       pll_locked_i    = 1'b1;
    logic                       resync_strobe_i = 1'b0;
    pixel_t                     sc_pixel_i      = '0;
    osd_t                       osd_i           = '0;
    capt_pixel_t                capt_pixel_o;
    logic [`OSSC_WORD_W-1:0]    controls_o;
    logic [`OSSC_WORD_W-1:0]    status_o;
    led_t                       led_o;
    logic                       ISL_RESET_N_o;
    logic                       HDMIRX_RESET_N_o;
    logic                       AUDMUX_o;
    i2s_t                       HDMITX_I2S_o;
    logic                       HDMITX_SPDIF_o;
    pixel_t                     HDMITX_PIXEL_o;

    logic [15:0] lfsr_state  = 16'd58524;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    int          cycle_count = 0;

    ossc_io #(
        .LED_CTR_W (LED_W)
    ) u_ossc_io (.*);

    initial begin
        forever #50 CLK27_i = ~CLK27_i;
    end

    always @(posedge CLK27_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1, newest bit at the LSB
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input bit ok,
                                 input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (!ok) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        compare_value(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_capt(input string name, input capt_pixel_t got, input capt_pixel_t exp);
        compare_value(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_word(input string name, input logic [`OSSC_WORD_W-1:0] got,
                              input logic [`OSSC_WORD_W-1:0] exp);
        compare_value(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        compare_value(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_i2s(input string name, input i2s_t got, input i2s_t exp);
        compare_value(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        compare_value(name, got === exp, 32'(got), 32'(exp));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("Test %s done, %0d errors", name, error_count - errors_before);
    endtask

    task automatic reset_state();
        int errors_before;
        errors_before = error_count;
        repeat (2) @(posedge CLK27_i);
        po_reset_n <= 1'b1;
        @(negedge CLK27_i);
        check_pixel("HDMITX_PIXEL_o", HDMITX_PIXEL_o, '0);
        // Standby with the PLL locked shows red only
        check_led("led_o", led_o, led_t'(3'b001));
        @(posedge CLK27_i);
        @(negedge CLK27_i);
        check_word("controls_o", controls_o, 32'h3f00_0000);
        finish_test("reset_state", errors_before);
    endtask

    task automatic capture_select();
        capt_pixel_t expected[$];
        capt_pixel_t pix;
        i2s_t        exp_i2s;
        logic [31:0] r;
        int          errors_before;
        errors_before = error_count;
        // Analog stream first, then HDMI with one more input stage
        for (int sel = 0; sel < 2; sel++) begin
            @(posedge CLK27_i);
            sys_ctrl_i.capture_sel <= sel[0];
            for (int i = 0; i < STREAM_LEN + 2 + sel; i++) begin
                @(posedge CLK27_i);
                if (i < STREAM_LEN) begin
                    r   = random_bits($bits(capt_pixel_t));
                    pix = r[$bits(capt_pixel_t)-1:0];
                    if (sel == 1) begin
                        hdmirx_pixel_i <= pix;
                    end else begin
                        isl_pixel_i <= pix;
                    end
                    expected.push_back(pix);
                end
                @(negedge CLK27_i);
                if (i >= 2 + sel) begin
                    check_capt("capt_pixel_o", capt_pixel_o, expected.pop_front());
                end
            end
        end
        // Audio routing over all four select combinations
        for (int k = 0; k < 4; k++) begin
            @(posedge CLK27_i);
            r = random_bits(3);
            sys_ctrl_i.capture_sel  <= k[0];
            sys_ctrl_i.hdmirx_spdif <= k[1];
            // Every audio source differs from the others in at least one bit
            hdmirx_i2s_i <= {r[2:1], ~r[0]};
            pcm_i2s_i    <= {~r[2:1], r[0]};
            hdmirx_ap_i  <= r[0];
            spdif_ext_i  <= ~r[0];
            @(negedge CLK27_i);
            exp_i2s = pcm_i2s_i;
            if (k[0]) begin
                exp_i2s      = hdmirx_i2s_i;
                exp_i2s.data = hdmirx_ap_i;
            end
            check_i2s("HDMITX_I2S_o", HDMITX_I2S_o, exp_i2s);
            check_bit("HDMITX_SPDIF_o", HDMITX_SPDIF_o, k[1] ? hdmirx_ap_i : spdif_ext_i);
        end
        finish_test("capture_select", errors_before);
    endtask

    task automatic overlay_colours();
        pixel_t      expected[$];
        pixel_t      pix;
        osd_t        osd;
        logic [31:0] r;
        int          errors_before;
        errors_before = error_count;
        // First half with OSD off, second half walks the four indices
        for (int i = 0; i < STREAM_LEN + 2; i++) begin
            @(posedge CLK27_i);
            if (i < STREAM_LEN) begin
                r          = random_bits($bits(pixel_t));
                pix        = r[$bits(pixel_t)-1:0];
                osd.enable = (i >= STREAM_LEN / 2);
                osd.color  = i[1:0];
                sc_pixel_i <= pix;
                osd_i      <= osd;
                if (osd.enable) begin
                    {pix.r, pix.g, pix.b} = OSD_PALETTE[osd.color];
                end
                expected.push_back(pix);
            end
            @(negedge CLK27_i);
            if (i >= 2) begin
                check_pixel("HDMITX_PIXEL_o", HDMITX_PIXEL_o, expected.pop_front());
            end
        end
        finish_test("overlay_colours", errors_before);
    endtask

    task automatic resync_indicator();
        led_t        exp_led;
        logic [31:0] r;
        int          cycles;
        int          errors_before;
        errors_before = error_count;
        @(posedge CLK27_i);
        sys_ctrl_i.poweron <= 1'b1;
        resync_strobe_i    <= 1'b1;
        cycles = 0;
        while (cycles == 0 || (!led_o.red && cycles < 4)) begin
            @(posedge CLK27_i);
            resync_strobe_i <= 1'b0;
            @(negedge CLK27_i);
            cycles++;
        end
        check_count++;
        if (!led_o.red) begin
            error_count++;
            $display("Red LED did not light within 4 cycles of the resync strobe");
        end
        while (led_o.red && cycles < CTR_CYCLES + 4) begin
            @(negedge CLK27_i);
            cycles++;
        end
        check_count++;
        if (led_o.red || cycles < CTR_CYCLES - 4) begin
            error_count++;
            $display("Red LED went off %0d cycles after the strobe, expected %0d +/- 4",
                     cycles, CTR_CYCLES);
        end
        for (int k = 0; k < 4; k++) begin
            @(posedge CLK27_i);
            r = random_bits(`OSSC_IR_CODE_W);
            sys_ctrl_i.framelock <= k[0];
            ir_code_i            <= k[1] ? r[`OSSC_IR_CODE_W-1:0] : '0;
            @(negedge CLK27_i);
            exp_led.blue  = k[0];
            exp_led.green = (ir_code_i == '0);
            exp_led.red   = 1'b0;
            check_led("led_o", led_o, exp_led);
        end
        finish_test("resync_indicator", errors_before);
    endtask

    task automatic cpu_words();
        logic [31:0]             r;
        logic [2:0]              pins;
        logic [`OSSC_WORD_W-1:0] exp_ctrl;
        logic [`OSSC_WORD_W-1:0] exp_stat;
        int                      errors_before;
        errors_before = error_count;
        for (int k = 0; k < WORD_ROUNDS; k++) begin
            @(posedge CLK27_i);
            // Buttons at 29:24, IR count at 23:16, IR code at 15:0
            r = random_bits(30);
            btn_i         <= r[29:24];
            ir_code_cnt_i <= r[23:16];
            ir_code_i     <= r[15:0];
            exp_ctrl = {2'b00, r[29:0]};
            r = random_bits(6);
            sd_detect_n_i <= r[5];
            mem_status_i  <= r[4:0];
            exp_stat = {26'd0, ~r[5], r[4:0]};
            // Front end resets and the inverted audio mux pin
            r    = random_bits(3);
            pins = r[2:0];
            sys_ctrl_i.isl_reset_n    <= pins[0];
            sys_ctrl_i.hdmirx_reset_n <= pins[1];
            sys_ctrl_i.audmux_sel     <= pins[2];
            repeat (3) @(posedge CLK27_i);
            @(negedge CLK27_i);
            check_word("controls_o", controls_o, exp_ctrl);
            check_word("status_o", status_o, exp_stat);
            check_bit("ISL_RESET_N_o", ISL_RESET_N_o, pins[0]);
            check_bit("HDMIRX_RESET_N_o", HDMIRX_RESET_N_o, pins[1]);
            check_bit("AUDMUX_o", AUDMUX_o, ~pins[2]);
        end
        finish_test("cpu_words", errors_before);
    endtask

    initial begin
        reset_state();
        capture_select();
        overlay_colours();
        resync_indicator();
        cpu_words();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
